//--- design/ex_pkg.sv
// Shared types for the execute stage; XLEN fixed at 32, register addresses at 6 bits, 2-level tree
`default_nettype none

package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 6;

  // Quantizer tree: 2 levels, 3 thresholds, 2-bit code
  localparam int unsigned QNT_LEVELS     = 2;
  localparam int unsigned QNT_NODE_W     = QNT_LEVELS + 1;
  localparam int unsigned QNT_WORD_BYTES = 4;

  ////////////////////
  // Operators
  ////////////////////
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic {
    MULT_MUL,   // low product
    MULT_MULH   // signed high product
  } mult_op_e;

  ////////////////////
  // Requests and ports
  ////////////////////
  typedef struct packed {
    logic            en;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
  } alu_req_t;

  typedef struct packed {
    logic            en;
    mult_op_e        op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } mult_req_t;

  typedef struct packed {
    logic            en;
    logic [XLEN-1:0] value;
    logic [XLEN-1:0] base;
  } qnt_req_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } fw_port_t;

endpackage

`default_nettype wire

//--- design/ex_alu.sv
// Purely combinational; shifts use b[4:0], compares return 0/1 and ignore req_i.en
`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  alu_req_t        req_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;
  logic            eq;
  logic            is_cmp;

  assign shamt = req_i.b[4:0];
  assign lt_s  = $signed(req_i.a) < $signed(req_i.b);
  assign lt_u  = req_i.a < req_i.b;
  assign eq    = req_i.a == req_i.b;

  ////////////////////
  // Comparisons
  ////////////////////
  always_comb begin
    is_cmp       = 1'b1;
    cmp_result_o = 1'b0;
    case (req_i.op)
      ALU_SLT, ALU_LT: cmp_result_o = lt_s;
      ALU_SLTU, ALU_LTU: cmp_result_o = lt_u;
      ALU_EQ:  cmp_result_o = eq;
      ALU_NE:  cmp_result_o = ~eq;
      ALU_GE:  cmp_result_o = ~lt_s;
      ALU_GEU: cmp_result_o = ~lt_u;
      default: is_cmp = 1'b0;
    endcase
  end

  ////////////////////
  // Result mux
  ////////////////////
  always_comb begin
    result_o = '0;
    if (is_cmp) begin
      result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    end else begin
      case (req_i.op)
        ALU_ADD: result_o = req_i.a + req_i.b;
        ALU_SUB: result_o = req_i.a - req_i.b;
        ALU_AND: result_o = req_i.a & req_i.b;
        ALU_OR:  result_o = req_i.a | req_i.b;
        ALU_XOR: result_o = req_i.a ^ req_i.b;
        ALU_SLL: result_o = req_i.a << shamt;
        ALU_SRL: result_o = req_i.a >> shamt;
        // Arithmetic shift keeps the sign
        ALU_SRA: result_o = $signed(req_i.a) >>> shamt;
        default: result_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/ex_mult.sv
// MUL is combinational; MULH takes two cycles and holds its result until ex_ready_i
`timescale 1ns/1ps
`default_nettype none

module ex_mult
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  mult_req_t       req_i,
  input  logic            ex_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  logic [2*XLEN-1:0] prod;
  logic [2*XLEN-1:0] prod_q;
  logic              is_mulh;
  logic              second_q;

  // Signed product, low half is the same for MUL
  assign prod    = $signed(req_i.a) * $signed(req_i.b);
  assign is_mulh = req_i.en & (req_i.op == MULT_MULH);

  // First MULH cycle stalls the stage
  assign multicycle_o = is_mulh & ~second_q;
  assign ready_o      = ~multicycle_o;

  assign result_o = second_q ? prod_q[2*XLEN-1:XLEN] : prod[XLEN-1:0];

  ////////////////////
  // Control
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_q <= 1'b0;
    end else if (multicycle_o) begin
      second_q <= 1'b1;
    end else if (ex_ready_i) begin
      second_q <= 1'b0;
    end
  end

  // Product register for the high half
  always_ff @(posedge clk) begin
    if (multicycle_o) begin
      prod_q <= prod;
    end
  end

endmodule

`default_nettype wire

//--- design/ex_qnt_unit.sv
// One read per tree level; req_i must stay stable until the result is taken
`timescale 1ns/1ps
`default_nettype none

module ex_qnt_unit
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  qnt_req_t        req_i,
  input  logic            ex_ready_i,
  input  logic            gnt_i,
  input  logic            rvalid_i,
  input  logic [XLEN-1:0] rdata_i,
  output logic            req_o,
  output logic [XLEN-1:0] addr_o,
  output logic [XLEN-1:0] result_o,
  output logic            ready_o
);

  typedef enum logic [1:0] {
    QNT_IDLE,
    QNT_REQ,
    QNT_WAIT,
    QNT_DONE
  } qnt_state_e;

  qnt_state_e            state_q;
  logic [QNT_NODE_W-1:0] node_q;
  logic [QNT_NODE_W-1:0] node_nxt;
  logic                  ge;

  // Go right when value >= threshold
  assign ge       = $signed(req_i.value) >= $signed(rdata_i);
  assign node_nxt = {node_q[QNT_LEVELS-1:0], ge};

  assign req_o    = (state_q == QNT_REQ);
  assign addr_o   = req_i.base + XLEN'(node_q) * XLEN'(QNT_WORD_BYTES);
  // Leaf index minus 2^QNT_LEVELS is the code
  assign result_o = XLEN'(node_q[QNT_LEVELS-1:0]);
  assign ready_o  = ((state_q == QNT_IDLE) & ~req_i.en) | (state_q == QNT_DONE);

  ////////////////////
  // Tree walk FSM
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= QNT_IDLE;
      node_q  <= '0;
    end else begin
      case (state_q)
        QNT_IDLE: begin
          if (req_i.en) begin
            state_q <= QNT_REQ;
            node_q  <= QNT_NODE_W'(1);
          end
        end
        QNT_REQ: begin
          if (gnt_i) begin
            state_q <= QNT_WAIT;
          end
        end
        QNT_WAIT: begin
          if (rvalid_i) begin
            node_q  <= node_nxt;
            state_q <= node_nxt[QNT_LEVELS] ? QNT_DONE : QNT_REQ;
          end
        end
        default: begin
          // Hold the code until the stage moves on
          if (ex_ready_i) begin
            state_q <= QNT_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/ex_wb_arbiter.sv
// Fixed priority CSR > quantizer > multiplier > ALU; we and waddr pass straight through
`timescale 1ns/1ps
`default_nettype none

module ex_wb_arbiter
  import ex_pkg::*;
(
  input  logic [XLEN-1:0]       alu_result_i,
  input  logic [XLEN-1:0]       mult_result_i,
  input  logic [XLEN-1:0]       qnt_result_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  mult_en_i,
  input  logic                  qnt_en_i,
  input  logic                  csr_access_i,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  output fw_port_t              fw_o
);

  always_comb begin
    fw_o.we    = we_i;
    fw_o.waddr = waddr_i;
    if (csr_access_i) begin
      fw_o.wdata = csr_rdata_i;
    end else if (qnt_en_i) begin
      fw_o.wdata = qnt_result_i;
    end else if (mult_en_i) begin
      fw_o.wdata = mult_result_i;
    end else begin
      // ALU owns the port by default
      fw_o.wdata = alu_result_i;
    end
  end

endmodule

`default_nettype wire

//--- design/ex_pipe_ctrl.sv
// Branches in EX force ready high; the load write address is only updated for real writes
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_ctrl (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       any_en_i,
  input  logic       units_ready_i,
  input  logic       lsu_ready_ex_i,
  input  logic       wb_ready_i,
  input  logic       branch_in_ex_i,
  input  logic       regfile_we_i,
  input  logic [5:0] regfile_waddr_i,
  input  logic       lsu_err_i,
  output logic       ex_ready_o,
  output logic       ex_valid_o,
  output logic       regfile_we_wb_o,
  output logic [5:0] regfile_waddr_wb_o
);

  logic all_ready;
  logic lsu_we;

  assign all_ready = units_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign lsu_we    = regfile_we_i & ~lsu_err_i;

  // Branches resolve here, no need to wait on WB
  assign ex_ready_o = all_ready | branch_in_ex_i;
  assign ex_valid_o = any_en_i & all_ready;

  ////////////////////
  // EX/WB register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= lsu_we;
    end else if (wb_ready_i) begin
      // Nothing new, flush the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

endmodule

`default_nettype wire

//--- design/ex_stage.sv
// Top of the execute stage; thresholds arrive on lsu_rdata_i, one instruction at a time
`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  alu_req_t              alu_req_i,
  input  mult_req_t             mult_req_i,
  input  qnt_req_t              qnt_req_i,
  input  logic                  csr_access_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  lsu_en_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  input  logic                  data_gnt_i,
  input  logic                  thresh_rvalid_i,
  output fw_port_t              fw_o,
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [XLEN-1:0]       regfile_wdata_wb_o,
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       jump_target_o,
  output logic                  mult_multicycle_o,
  output logic                  qnt_thresh_req_o,
  output logic [XLEN-1:0]       qnt_thresh_addr_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mult_result;
  logic [XLEN-1:0] qnt_result;
  logic            mult_ready;
  logic            qnt_ready;
  logic            any_en;

  assign any_en = alu_req_i.en | mult_req_i.en | qnt_req_i.en | csr_access_i | lsu_en_i;
  assign jump_target_o      = alu_req_i.c;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  ////////////////////
  // Units
  ////////////////////
  ex_alu u_alu (.req_i(alu_req_i), .result_o(alu_result), .cmp_result_o(branch_decision_o));

  ex_mult u_mult (
    .clk, .rst_n, .req_i(mult_req_i), .ex_ready_i(ex_ready_o),
    .result_o(mult_result), .multicycle_o(mult_multicycle_o), .ready_o(mult_ready)
  );

  ex_qnt_unit u_qnt (
    .clk, .rst_n, .req_i(qnt_req_i), .ex_ready_i(ex_ready_o),
    .gnt_i(data_gnt_i), .rvalid_i(thresh_rvalid_i), .rdata_i(lsu_rdata_i),
    .req_o(qnt_thresh_req_o), .addr_o(qnt_thresh_addr_o),
    .result_o(qnt_result), .ready_o(qnt_ready)
  );

  ////////////////////
  // Writeback and control
  ////////////////////
  ex_wb_arbiter u_arb (
    .alu_result_i(alu_result), .mult_result_i(mult_result), .qnt_result_i(qnt_result),
    .csr_rdata_i, .mult_en_i(mult_req_i.en), .qnt_en_i(qnt_req_i.en), .csr_access_i,
    .we_i(regfile_alu_we_i), .waddr_i(regfile_alu_waddr_i), .fw_o
  );

  ex_pipe_ctrl u_ctrl (
    .clk, .rst_n, .any_en_i(any_en), .units_ready_i(mult_ready & qnt_ready),
    .lsu_ready_ex_i, .wb_ready_i, .branch_in_ex_i, .regfile_we_i, .regfile_waddr_i,
    .lsu_err_i, .ex_ready_o, .ex_valid_o, .regfile_we_wb_o, .regfile_waddr_wb_o
  );

endmodule

`default_nettype wire

//--- verification/ex_tb_clk.sv
// Free-running 10 ns clock from time 0; rst_n low until the third rising edge
`timescale 1ns/1ps
`default_nettype none

module ex_tb_clk (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int RST_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/ex_stage_tb.sv
// Checks run as concurrent assertions (build with --assert); threshold grants lag 0-3 cycles
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb
  import ex_pkg::*;
;

  localparam int WAIT_MAX = 50;

  logic                   clk;
  logic                   rst_n;
  alu_req_t               alu_req;
  mult_req_t              mult_req;
  qnt_req_t               qnt_req;
  logic                   csr_access;
  logic [XLEN-1:0]        csr_rdata;
  logic                   alu_we;
  logic [REG_ADDR_W-1:0]  alu_waddr;
  logic                   rf_we;
  logic [REG_ADDR_W-1:0]  rf_waddr;
  logic                   lsu_en;
  logic                   lsu_ready;
  logic                   lsu_err;
  logic                   branch_in_ex;
  logic                   wb_ready;
  // Driven only by the threshold memory model
  logic                   data_gnt = 1'b0;
  logic                   thr_rvalid = 1'b0;
  logic [XLEN-1:0]        lsu_rdata = '0;
  fw_port_t               fw;
  logic                   we_wb;
  logic [REG_ADDR_W-1:0]  waddr_wb;
  logic [XLEN-1:0]        wdata_wb;
  logic                   branch_dec;
  logic [XLEN-1:0]        jump_tgt;
  logic                   mult_mc;
  logic                   thr_req;
  logic [XLEN-1:0]        thr_addr;
  logic                   ex_ready;
  logic                   ex_valid;

  // Expected values and check enables
  logic [XLEN-1:0]        exp_wdata = '0;
  logic                   exp_branch = 1'b0;
  logic [XLEN-1:0]        exp_target = '0;
  logic [XLEN-1:0]        exp_addr;
  logic [REG_ADDR_W-1:0]  exp_waddr_wb = '0;
  logic                   chk_wdata = 1'b0;
  logic                   chk_valid = 1'b0;
  logic                   chk_branch = 1'b0;
  logic                   chk_mulh = 1'b0;

  integer                 seed = 32'h404d_0121;
  logic signed [XLEN-1:0] thr [1:3];
  int                     tb_node = 1;
  int                     gnt_delay = -1;
  int                     err_cnt = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  int                     test_err0 = 0;
  string                  test_name;

  ex_tb_clk u_clk (.clk_o(clk), .rst_n_o(rst_n));

  ex_stage DUT (
    .clk(clk), .rst_n(rst_n), .alu_req_i(alu_req), .mult_req_i(mult_req), .qnt_req_i(qnt_req),
    .csr_access_i(csr_access), .csr_rdata_i(csr_rdata),
    .regfile_alu_we_i(alu_we), .regfile_alu_waddr_i(alu_waddr),
    .regfile_we_i(rf_we), .regfile_waddr_i(rf_waddr),
    .lsu_en_i(lsu_en), .lsu_rdata_i(lsu_rdata), .lsu_ready_ex_i(lsu_ready), .lsu_err_i(lsu_err),
    .branch_in_ex_i(branch_in_ex), .wb_ready_i(wb_ready),
    .data_gnt_i(data_gnt), .thresh_rvalid_i(thr_rvalid),
    .fw_o(fw), .regfile_we_wb_o(we_wb), .regfile_waddr_wb_o(waddr_wb),
    .regfile_wdata_wb_o(wdata_wb), .branch_decision_o(branch_dec), .jump_target_o(jump_tgt),
    .mult_multicycle_o(mult_mc), .qnt_thresh_req_o(thr_req), .qnt_thresh_addr_o(thr_addr),
    .ex_ready_o(ex_ready), .ex_valid_o(ex_valid)
  );

  ////////////////////
  // Threshold memory
  ////////////////////
  assign exp_addr = qnt_req.base + 32'(tb_node) * 32'd4;

  // Grant after a random delay, data one cycle after the grant, node walk per read
  always @(posedge clk) begin
    if (!qnt_req.en) begin
      tb_node <= 1;
    end
    thr_rvalid <= 1'b0;
    if (data_gnt) begin
      data_gnt   <= 1'b0;
      thr_rvalid <= 1'b1;
      lsu_rdata  <= thr[tb_node];
      tb_node    <= 2 * tb_node + (($signed(qnt_req.value) >= thr[tb_node]) ? 1 : 0);
    end else if (thr_req && !thr_rvalid) begin
      if (gnt_delay < 0) begin
        gnt_delay = $unsigned($random(seed)) % 4;
      end
      if (gnt_delay == 0) begin
        data_gnt  <= 1'b1;
        gnt_delay = -1;
      end else begin
        gnt_delay = gnt_delay - 1;
      end
    end
  end

  ////////////////////
  // Reporting
  ////////////////////
  task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
    err_cnt++;
    $display("ERR %0t %s exp %h got %h", $time, sig, exp, got);
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    @(posedge clk);
    @(negedge clk);
    tests_run++;
    if (err_cnt != test_err0) begin
      tests_failed++;
    end
    $display("test %-10s %s, %0d errors", test_name,
             (err_cnt == test_err0) ? "ok" : "failed", err_cnt - test_err0);
  endtask

  ////////////////////
  // Assertions
  ////////////////////
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    chk_wdata && ex_ready |-> fw.wdata == exp_wdata)
    else report_mismatch("fw_o.wdata", $sampled(exp_wdata), $sampled(fw.wdata));

  a_fw_we: assert property (@(posedge clk) disable iff (!rst_n) fw.we == alu_we)
    else report_mismatch("fw_o.we", {31'b0, $sampled(alu_we)}, {31'b0, $sampled(fw.we)});

  a_fw_waddr: assert property (@(posedge clk) disable iff (!rst_n) fw.waddr == alu_waddr)
    else report_mismatch("fw_o.waddr", 32'($sampled(alu_waddr)), 32'($sampled(fw.waddr)));

  a_valid: assert property (@(posedge clk) disable iff (!rst_n) chk_valid |-> ex_valid)
    else report_mismatch("ex_valid_o", 32'd1, 32'd0);

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    chk_branch |-> branch_dec == exp_branch)
    else report_mismatch("branch_decision_o", {31'b0, $sampled(exp_branch)},
                         {31'b0, $sampled(branch_dec)});

  a_target: assert property (@(posedge clk) disable iff (!rst_n)
    chk_branch |-> jump_tgt == exp_target)
    else report_mismatch("jump_target_o", $sampled(exp_target), $sampled(jump_tgt));

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready |-> !ex_valid && (ex_ready == branch_in_ex))
    else report_failure("ex_valid_o or ex_ready_o wrong while wb_ready_i is low");

  a_mc_stall: assert property (@(posedge clk) disable iff (!rst_n) mult_mc |-> !ex_ready)
    else report_failure("ex_ready_o high during the first MULH cycle");

  a_mulh_start: assert property (@(posedge clk) disable iff (!rst_n)
    chk_mulh && $rose(mult_req.en) |-> mult_mc)
    else report_failure("MULH request did not raise mult_multicycle_o");

  a_mulh_one: assert property (@(posedge clk) disable iff (!rst_n)
    chk_mulh && mult_mc |=> !mult_mc && ex_ready)
    else report_failure("MULH stall did not end after exactly one cycle");

  a_qnt_addr: assert property (@(posedge clk) disable iff (!rst_n)
    thr_req |-> thr_addr == exp_addr)
    else report_mismatch("qnt_thresh_addr_o", $sampled(exp_addr), $sampled(thr_addr));

  a_qnt_done: assert property (@(posedge clk) disable iff (!rst_n)
    qnt_req.en && ex_ready |-> tb_node >= 4)
    else report_failure("ex_ready_o high before the quantizer read every tree level");

  a_wb_load: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid |=> we_wb == $past(rf_we & ~lsu_err))
    else report_mismatch("regfile_we_wb_o", {31'b0, ~$sampled(we_wb)}, {31'b0, $sampled(we_wb)});

  a_wb_clear: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_valid && wb_ready |=> !we_wb)
    else report_mismatch("regfile_we_wb_o", 32'd0, {31'b0, $sampled(we_wb)});

  // Address of the last load write accepted into the EX/WB slot
  always @(posedge clk) begin
    if (ex_valid && rf_we && !lsu_err) begin
      exp_waddr_wb <= rf_waddr;
    end
  end

  a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
    we_wb |-> waddr_wb == exp_waddr_wb)
    else report_mismatch("regfile_waddr_wb_o", 32'($sampled(exp_waddr_wb)),
                         32'($sampled(waddr_wb)));

  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n) wdata_wb == lsu_rdata)
    else report_mismatch("regfile_wdata_wb_o", $sampled(lsu_rdata), $sampled(wdata_wb));

  a_reset: assert property (@(posedge clk) !rst_n |-> !thr_req && !mult_mc && !we_wb)
    else report_failure("an output was not low during reset");

  ////////////////////
  // Stimulus helpers
  ////////////////////
  function automatic logic [31:0] alu_expect(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ALU_ADD:           return a + b;
      ALU_SUB:           return a - b;
      ALU_AND:           return a & b;
      ALU_OR:            return a | b;
      ALU_XOR:           return a ^ b;
      ALU_SLL:           return a << b[4:0];
      ALU_SRL:           return a >> b[4:0];
      ALU_SRA:           return $signed(a) >>> b[4:0];
      ALU_SLT, ALU_LT:   return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU, ALU_LTU: return {31'b0, a < b};
      ALU_EQ:            return {31'b0, a == b};
      ALU_NE:            return {31'b0, a != b};
      ALU_GE:            return {31'b0, $signed(a) >= $signed(b)};
      default:           return {31'b0, a >= b};
    endcase
  endfunction

  task automatic wait_ex_ready(input string what);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < WAIT_MAX && !seen; n++) begin
      @(negedge clk);
      seen = ex_ready;
    end
    if (!seen) begin
      $display("timeout: ex_ready_o stayed low for %0d cycles during %s", WAIT_MAX, what);
      $display("RESULT: FAIL");
      $finish;
    end
  endtask

  task automatic wait_reset_release();
    for (int n = 0; n < WAIT_MAX && !rst_n; n++) begin
      @(negedge clk);
    end
    if (!rst_n) begin
      $display("timeout: reset never released");
      $display("RESULT: FAIL");
      $finish;
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    alu_req    <= '0;
    mult_req   <= '0;
    qnt_req    <= '0;
    csr_access <= 1'b0;
    lsu_en     <= 1'b0;
    chk_wdata  <= 1'b0;
    chk_valid  <= 1'b0;
    chk_branch <= 1'b0;
    chk_mulh   <= 1'b0;
  endtask

  task automatic drive_alu(input alu_op_e op, input logic check_branch);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] r;
    a = $random(seed);
    // Equal operands now and then for EQ and GE
    b = (($random(seed) & 3) == 0) ? a : $random(seed);
    c = $random(seed) & ~32'h1;
    r = alu_expect(op, a, b);
    @(posedge clk);
    alu_req    <= '{en: 1'b1, op: op, a: a, b: b, c: c};
    alu_we     <= 1'($random(seed));
    alu_waddr  <= 6'($random(seed));
    exp_wdata  <= r;
    exp_branch <= r[0];
    exp_target <= c;
    chk_wdata  <= 1'b1;
    chk_branch <= check_branch;
  endtask

  task automatic drive_mult(input mult_op_e op);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] p;
    a = $random(seed);
    b = $random(seed);
    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    @(posedge clk);
    mult_req  <= '{en: 1'b1, op: op, a: a, b: b};
    exp_wdata <= (op == MULT_MULH) ? p[63:32] : p[31:0];
    chk_wdata <= 1'b1;
    chk_valid <= (op == MULT_MUL);
    chk_mulh  <= (op == MULT_MULH);
  endtask

  task automatic run_qnt();
    logic signed [31:0] s [0:2];
    logic signed [31:0] t;
    logic signed [31:0] v;
    logic [31:0]        base;
    int                 code;
    for (int k = 0; k < 3; k++) begin
      s[k] = $random(seed) % 1000;
    end
    for (int m = 0; m < 2; m++) begin
      for (int k = 0; k < 2 - m; k++) begin
        if (s[k] > s[k+1]) begin
          t      = s[k];
          s[k]   = s[k+1];
          s[k+1] = t;
        end
      end
    end
    v    = $random(seed) % 1200;
    code = 0;
    for (int k = 0; k < 3; k++) begin
      code += (s[k] <= v) ? 1 : 0;
    end
    // Middle threshold at the root, smaller left, larger right
    thr[1] = s[1];
    thr[2] = s[0];
    thr[3] = s[2];
    base   = $random(seed) & ~32'h3;
    @(posedge clk);
    qnt_req   <= '{en: 1'b1, value: v, base: base};
    exp_wdata <= 32'(code);
    chk_wdata <= 1'b1;
    wait_ex_ready("quantization");
    go_idle();
    @(negedge clk);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    alu_req      = '0;
    mult_req     = '0;
    qnt_req      = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    alu_we       = 1'b0;
    alu_waddr    = '0;
    rf_we        = 1'b0;
    rf_waddr     = '0;
    lsu_en       = 1'b0;
    lsu_ready    = 1'b1;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
    thr[1]       = '0;
    thr[2]       = '0;
    thr[3]       = '0;
    wait_reset_release();

    start_test("alu");
    for (int i = 0; i < 40; i++) begin
      drive_alu(alu_op_e'(4'($random(seed))), 1'b0);
      chk_valid <= 1'b1;
    end
    go_idle();
    end_test();

    start_test("branch");
    for (int i = 0; i < 24; i++) begin
      drive_alu(alu_op_e'(4'd10 + 4'($unsigned($random(seed)) % 6)), 1'b1);
      chk_valid    <= (i < 16);
      branch_in_ex <= (i >= 16);
      wb_ready     <= (i < 16);
    end
    go_idle();
    branch_in_ex <= 1'b0;
    wb_ready     <= 1'b1;
    end_test();

    start_test("mult");
    for (int i = 0; i < 12; i++) begin
      drive_mult(MULT_MUL);
    end
    go_idle();
    for (int i = 0; i < 10; i++) begin
      drive_mult(MULT_MULH);
      wait_ex_ready("MULH");
      go_idle();
    end
    end_test();

    start_test("quantize");
    for (int i = 0; i < 12; i++) begin
      run_qnt();
    end
    end_test();

    start_test("writeback");
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      lsu_en   <= 1'($random(seed));
      rf_we    <= 1'($random(seed));
      rf_waddr <= 6'($random(seed));
      lsu_err  <= (($random(seed) & 3) == 0);
      wb_ready <= (($random(seed) & 3) != 0);
    end
    go_idle();
    wb_ready <= 1'b1;
    // CSR read beats a live multiply on the forwarding port
    for (int i = 0; i < 6; i++) begin
      drive_mult(MULT_MUL);
      csr_access <= 1'b1;
      csr_rdata  <= 32'(i) * 32'h0101_0101 + 32'h1234_5678;
      exp_wdata  <= 32'(i) * 32'h0101_0101 + 32'h1234_5678;
    end
    go_idle();
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- riscv_ex.f
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_qnt_unit.sv
design/ex_wb_arbiter.sv
design/ex_pipe_ctrl.sv
design/ex_stage.sv
verification/ex_tb_clk.sv
verification/ex_stage_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
TOP        ?= ex_stage_tb
RTL_TOP    ?= ex_stage
FLIST      ?= riscv_ex.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := RESULT: PASS
RTL_FILES  := $(filter design/%,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
